// ==== hdl/lagd_pkg.sv ====
package lagd_pkg;

    // default sizes of the macro
    parameter int NUM_SPIN_DEF        = 16;
    parameter int BITJ_DEF            = 4;
    parameter int BITH_DEF            = 4;
    parameter int PARALLELISM_DEF     = 4;
    parameter int FLIP_ICON_DEPTH_DEF = 16;
    parameter int SCALING_BIT         = 4;

    parameter int ENERGY_BIT = 32;

    typedef logic signed [ENERGY_BIT-1:0] energy_t;

    // unsigned field scaling for the h term
    typedef logic [SCALING_BIT-1:0] scaling_t;

    typedef enum logic [1:0] {
        EM_IDLE,
        EM_ACCUM,
        EM_DONE
    } em_state_e;

    typedef enum logic [2:0] {
        FM_IDLE,
        FM_FETCH,
        FM_BUILD,
        FM_SEND,
        FM_WAIT_E
    } fm_state_e;

endpackage

// ==== hdl/energy_if.sv ====
`timescale 1ns/1ps

// energy result with the spin vector it belongs to
interface energy_if #(
    parameter int NUM_SPIN = 16
) ();
    import lagd_pkg::*;

    logic                valid;
    logic                ready;
    energy_t             energy;
    logic [NUM_SPIN-1:0] spin;

    modport src (output valid, output energy, output spin, input ready);

    modport dst (input valid, input energy, input spin, output ready);

endinterface

// ==== hdl/step_counter.sv ====
`timescale 1ns/1ps

module step_counter #(
    parameter int COUNTER_BITWIDTH = 4,
    parameter int PARALLELISM      = 4
) (
    input  logic                        clk_i,
    input  logic                        arst_n_i,
    input  logic                        clear_i,
    input  logic                        step_en_i,
    output logic [COUNTER_BITWIDTH-1:0] q_o,
    output logic                        maxed_o
);

    // first row of the last group
    localparam logic [COUNTER_BITWIDTH-1:0] MAX_Q =
        COUNTER_BITWIDTH'((2 ** COUNTER_BITWIDTH) - PARALLELISM);

    logic [COUNTER_BITWIDTH-1:0] q_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            q_q <= '0;
        end else if (clear_i) begin
            q_q <= '0;
        end else if (step_en_i) begin
            // wrap back after the last group
            if (q_q == MAX_Q) begin
                q_q <= '0;
            end else begin
                q_q <= q_q + COUNTER_BITWIDTH'(PARALLELISM);
            end
        end
    end

    assign q_o     = q_q;
    assign maxed_o = (q_q == MAX_Q);

endmodule

// ==== hdl/energy_monitor.sv ====
`timescale 1ns/1ps

module energy_monitor #(
    parameter int NUM_SPIN    = 16,
    parameter int BITJ        = 4,
    parameter int BITH        = 4,
    parameter int PARALLELISM = 4
) (
    input  logic                                clk_i,
    input  logic                                arst_n_i,
    // candidate from the flip manager
    input  logic                                cand_valid_i,
    input  logic [NUM_SPIN-1:0]                 cand_spin_i,
    output logic                                cand_ready_o,
    // weight stream
    input  logic                                weight_valid_i,
    output logic                                weight_ready_o,
    input  logic [NUM_SPIN*BITJ*PARALLELISM-1:0] weight_i,
    input  logic [NUM_SPIN*BITH-1:0]            hbias_i,
    input  lagd_pkg::scaling_t                  hscaling_i,
    // row counter
    input  logic [$clog2(NUM_SPIN)-1:0]         row_i,
    input  logic                                row_last_i,
    output logic                                row_step_o,
    energy_if.src                               res
);
    import lagd_pkg::*;

    localparam int ROW_W = NUM_SPIN * BITJ;

    em_state_e           state_q;
    logic [NUM_SPIN-1:0] spin_q;
    energy_t             acc_q;
    energy_t             beat_sum;
    logic                cand_fire;
    logic                beat_fire;

    // s_i * (sum_j J_ij * s_j + hscaling * h_i)
    function automatic energy_t row_energy(
        input logic [ROW_W-1:0]     row,
        input logic [NUM_SPIN-1:0]  s,
        input logic                 s_i,
        input logic signed [BITH-1:0] h,
        input scaling_t             sc
    );
        energy_t sum;
        energy_t coup;
        energy_t h_term;
        sum = '0;
        for (int j = 0; j < NUM_SPIN; j++) begin
            coup = energy_t'($signed(row[j*BITJ +: BITJ]));
            // bit 1 is +1, bit 0 is -1
            if (s[j]) begin
                sum = sum + coup;
            end else begin
                sum = sum - coup;
            end
        end
        h_term = energy_t'(h) * energy_t'(sc);
        sum = sum + h_term;
        return s_i ? sum : -sum;
    endfunction

    always_comb begin
        beat_sum = '0;
        for (int r = 0; r < PARALLELISM; r++) begin
            beat_sum = beat_sum + row_energy(
                weight_i[r*ROW_W +: ROW_W],
                spin_q,
                spin_q[row_i + r],
                hbias_i[(row_i + r)*BITH +: BITH],
                hscaling_i
            );
        end
    end

    assign cand_ready_o   = (state_q == EM_IDLE);
    assign weight_ready_o = (state_q == EM_ACCUM);
    assign cand_fire      = cand_valid_i && cand_ready_o;
    assign beat_fire      = weight_valid_i && weight_ready_o;
    assign row_step_o     = beat_fire;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= EM_IDLE;
        end else begin
            case (state_q)
                EM_IDLE: begin
                    if (cand_fire) begin
                        state_q <= EM_ACCUM;
                    end
                end
                EM_ACCUM: begin
                    if (beat_fire && row_last_i) begin
                        state_q <= EM_DONE;
                    end
                end
                EM_DONE: begin
                    // held until the flip manager takes the result
                    if (res.ready) begin
                        state_q <= EM_IDLE;
                    end
                end
                default: state_q <= EM_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (cand_fire) begin
            spin_q <= cand_spin_i;
            acc_q  <= '0;
        end else if (beat_fire) begin
            acc_q <= acc_q + beat_sum;
        end
    end

    // energy carries the minus sign of the Ising form
    assign res.valid  = (state_q == EM_DONE);
    assign res.energy = -acc_q;
    assign res.spin   = spin_q;

endmodule

// ==== hdl/flip_manager.sv ====
`timescale 1ns/1ps

module flip_manager #(
    parameter int NUM_SPIN        = 16,
    parameter int FLIP_ICON_DEPTH = 16
) (
    input  logic                               clk_i,
    input  logic                               arst_n_i,
    input  logic                               config_valid_i,
    input  logic [NUM_SPIN-1:0]                config_spin_i,
    input  logic                               cmpt_en_i,
    input  logic                               en_comparison_i,
    output logic                               cmpt_idle_o,
    // flip icon memory
    output logic                               flip_ren_o,
    output logic [$clog2(FLIP_ICON_DEPTH)-1:0] flip_raddr_o,
    input  logic [NUM_SPIN-1:0]                flip_rdata_i,
    input  logic [$clog2(FLIP_ICON_DEPTH):0]   icon_count_i,
    // candidate to the energy monitor
    output logic                               cand_valid_o,
    output logic [NUM_SPIN-1:0]                cand_spin_o,
    input  logic                               cand_ready_i,
    energy_if.dst                              res,
    output logic [NUM_SPIN-1:0]                spin_o,
    output lagd_pkg::energy_t                  energy_o
);
    import lagd_pkg::*;

    localparam int ADDR_BIT = $clog2(FLIP_ICON_DEPTH);

    fm_state_e           state_q;
    logic [ADDR_BIT:0]   icon_idx_q;
    logic                first_q;
    logic [NUM_SPIN-1:0] spin_q;
    energy_t             energy_q;
    logic [NUM_SPIN-1:0] cand_q;
    logic                accept;

    // initial evaluation is always taken
    assign accept = first_q || !en_comparison_i || (res.energy < energy_q);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= FM_IDLE;
            icon_idx_q <= '0;
            first_q    <= 1'b0;
            spin_q     <= '0;
            energy_q   <= '0;
        end else begin
            case (state_q)
                FM_IDLE: begin
                    if (config_valid_i) begin
                        spin_q <= config_spin_i;
                    end
                    if (cmpt_en_i) begin
                        icon_idx_q <= '0;
                        first_q    <= 1'b1;
                        state_q    <= FM_SEND;
                    end
                end
                FM_FETCH: state_q <= FM_BUILD;
                FM_BUILD: begin
                    icon_idx_q <= icon_idx_q + 1'b1;
                    state_q    <= FM_SEND;
                end
                FM_SEND: begin
                    if (cand_ready_i) begin
                        state_q <= FM_WAIT_E;
                    end
                end
                FM_WAIT_E: begin
                    if (res.valid) begin
                        if (accept) begin
                            spin_q   <= res.spin;
                            energy_q <= res.energy;
                        end
                        first_q <= 1'b0;
                        if (icon_idx_q == icon_count_i) begin
                            state_q <= FM_IDLE;
                        end else begin
                            state_q <= FM_FETCH;
                        end
                    end
                end
                default: state_q <= FM_IDLE;
            endcase
        end
    end

    // candidate base is the state after the last decision
    always_ff @(posedge clk_i) begin
        if (state_q == FM_IDLE && cmpt_en_i) begin
            cand_q <= config_valid_i ? config_spin_i : spin_q;
        end else if (state_q == FM_BUILD) begin
            cand_q <= spin_q ^ flip_rdata_i;
        end
    end

    assign cmpt_idle_o  = (state_q == FM_IDLE);
    assign flip_ren_o   = (state_q == FM_FETCH);
    assign flip_raddr_o = icon_idx_q[ADDR_BIT-1:0];
    assign cand_valid_o = (state_q == FM_SEND);
    assign cand_spin_o  = cand_q;
    assign res.ready    = (state_q == FM_WAIT_E);
    assign spin_o       = spin_q;
    assign energy_o     = energy_q;

endmodule

// ==== hdl/digital_macro.sv ====
`timescale 1ns/1ps

module digital_macro #(
    parameter int NUM_SPIN        = lagd_pkg::NUM_SPIN_DEF,
    parameter int BITJ            = lagd_pkg::BITJ_DEF,
    parameter int BITH            = lagd_pkg::BITH_DEF,
    parameter int PARALLELISM     = lagd_pkg::PARALLELISM_DEF,
    parameter int FLIP_ICON_DEPTH = lagd_pkg::FLIP_ICON_DEPTH_DEF
) (
    input  logic                                      clk_i,
    input  logic                                      arst_n_i,
    // config and run control
    input  logic                                      config_valid_i,
    input  logic [NUM_SPIN-1:0]                       config_spin_i,
    input  logic                                      cmpt_en_i,
    input  logic                                      en_comparison_i,
    output logic                                      cmpt_idle_o,
    // flip icon memory
    output logic                                      flip_ren_o,
    output logic [$clog2(FLIP_ICON_DEPTH)-1:0]        flip_raddr_o,
    input  logic [NUM_SPIN-1:0]                       flip_rdata_i,
    input  logic [$clog2(FLIP_ICON_DEPTH):0]          icon_count_i,
    // weight memory
    input  logic                                      weight_valid_i,
    output logic                                      weight_ready_o,
    output logic [$clog2(NUM_SPIN/PARALLELISM)-1:0]   weight_raddr_o,
    input  logic [NUM_SPIN*BITJ*PARALLELISM-1:0]      weight_i,
    input  logic [NUM_SPIN*BITH-1:0]                  hbias_i,
    input  lagd_pkg::scaling_t                        hscaling_i,
    // final state
    output logic [NUM_SPIN-1:0]                       spin_o,
    output lagd_pkg::energy_t                         energy_o
);

    localparam int ROW_BIT   = $clog2(NUM_SPIN);
    localparam int RADDR_BIT = $clog2(NUM_SPIN / PARALLELISM);

    logic                cand_valid;
    logic                cand_ready;
    logic [NUM_SPIN-1:0] cand_spin;
    logic [ROW_BIT-1:0]  row_q;
    logic [ROW_BIT-1:0]  row_group;
    logic                row_maxed;
    logic                row_step;

    energy_if #(.NUM_SPIN(NUM_SPIN)) u_energy_if ();

    // one address per group of PARALLELISM rows
    assign row_group      = row_q / ROW_BIT'(PARALLELISM);
    assign weight_raddr_o = row_group[RADDR_BIT-1:0];

    step_counter #(
        .COUNTER_BITWIDTH (ROW_BIT     ),
        .PARALLELISM      (PARALLELISM )
    ) u_step_counter (
        .clk_i     (clk_i                   ),
        .arst_n_i  (arst_n_i                ),
        .clear_i   (cand_valid && cand_ready),
        .step_en_i (row_step                ),
        .q_o       (row_q                   ),
        .maxed_o   (row_maxed               )
    );

    energy_monitor #(
        .NUM_SPIN    (NUM_SPIN    ),
        .BITJ        (BITJ        ),
        .BITH        (BITH        ),
        .PARALLELISM (PARALLELISM )
    ) u_energy_monitor (
        .clk_i          (clk_i          ),
        .arst_n_i       (arst_n_i       ),
        .cand_valid_i   (cand_valid     ),
        .cand_spin_i    (cand_spin      ),
        .cand_ready_o   (cand_ready     ),
        .weight_valid_i (weight_valid_i ),
        .weight_ready_o (weight_ready_o ),
        .weight_i       (weight_i       ),
        .hbias_i        (hbias_i        ),
        .hscaling_i     (hscaling_i     ),
        .row_i          (row_q          ),
        .row_last_i     (row_maxed      ),
        .row_step_o     (row_step       ),
        .res            (u_energy_if.src)
    );

    flip_manager #(
        .NUM_SPIN        (NUM_SPIN        ),
        .FLIP_ICON_DEPTH (FLIP_ICON_DEPTH )
    ) u_flip_manager (
        .clk_i           (clk_i          ),
        .arst_n_i        (arst_n_i       ),
        .config_valid_i  (config_valid_i ),
        .config_spin_i   (config_spin_i  ),
        .cmpt_en_i       (cmpt_en_i      ),
        .en_comparison_i (en_comparison_i),
        .cmpt_idle_o     (cmpt_idle_o    ),
        .flip_ren_o      (flip_ren_o     ),
        .flip_raddr_o    (flip_raddr_o   ),
        .flip_rdata_i    (flip_rdata_i   ),
        .icon_count_i    (icon_count_i   ),
        .cand_valid_o    (cand_valid     ),
        .cand_spin_o     (cand_spin      ),
        .cand_ready_i    (cand_ready     ),
        .res             (u_energy_if.dst),
        .spin_o          (spin_o         ),
        .energy_o        (energy_o       )
    );

endmodule

// ==== verif/tb_digital_macro.sv ====
`timescale 1ns/1ps

module tb_digital_macro;
    import lagd_pkg::*;

    localparam int N           = 16;
    localparam int ICONS       = 16;
    localparam int RUNS        = 7;
    localparam int EVAL_CYCLES = 60;
    localparam int RUN_LIMIT   = (ICONS + 1) * EVAL_CYCLES;
    localparam int MAX_CYCLES  = 2 * RUNS * RUN_LIMIT;

    logic             clk_i = 1'b0;
    logic             arst_n_i;
    logic             config_valid_i;
    logic [N-1:0]     config_spin_i;
    logic             cmpt_en_i;
    logic             en_comparison_i;
    logic             cmpt_idle_o;
    logic             flip_ren_o;
    logic [3:0]       flip_raddr_o;
    logic [N-1:0]     flip_rdata_i = '0;
    logic [4:0]       icon_count_i;
    logic             weight_valid_i;
    logic             weight_ready_o;
    logic [1:0]       weight_raddr_o;
    logic [N*16-1:0]  weight_i;
    logic [N*4-1:0]   hbias_i;
    scaling_t         hscaling_i;
    logic [N-1:0]     spin_o;
    energy_t          energy_o;

    logic [N*16-1:0]  j_mem [4];
    logic [N-1:0]     icon_mem [ICONS];
    int               j_val [N][N];
    int               h_val [N];
    int               seed;
    int               errors;
    int               checks;
    int               test_num;
    int               err_mark;
    int               cycles = 0;
    logic             rd_pend = 1'b0;
    logic [3:0]       rd_addr = '0;
    logic [N-1:0]     start_spin;
    logic [N-1:0]     ref_spin;
    logic [31:0]      ref_energy;
    logic [N-1:0]     got_spin;
    logic [31:0]      got_energy;

    digital_macro uut (
        .clk_i           (clk_i          ),
        .arst_n_i        (arst_n_i       ),
        .config_valid_i  (config_valid_i ),
        .config_spin_i   (config_spin_i  ),
        .cmpt_en_i       (cmpt_en_i      ),
        .en_comparison_i (en_comparison_i),
        .cmpt_idle_o     (cmpt_idle_o    ),
        .flip_ren_o      (flip_ren_o     ),
        .flip_raddr_o    (flip_raddr_o   ),
        .flip_rdata_i    (flip_rdata_i   ),
        .icon_count_i    (icon_count_i   ),
        .weight_valid_i  (weight_valid_i ),
        .weight_ready_o  (weight_ready_o ),
        .weight_raddr_o  (weight_raddr_o ),
        .weight_i        (weight_i       ),
        .hbias_i         (hbias_i        ),
        .hscaling_i      (hscaling_i     ),
        .spin_o          (spin_o         ),
        .energy_o        (energy_o       )
    );

    always #10 clk_i = ~clk_i;

    // weight memory answers in the same cycle
    assign weight_i = j_mem[weight_raddr_o];

    // icon memory data one cycle after the read strobe
    always @(negedge clk_i) begin
        if (rd_pend) begin
            flip_rdata_i = icon_mem[rd_addr];
        end
        rd_pend = flip_ren_o;
        rd_addr = flip_raddr_o;
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("simulation stopped after %0d cycles without finishing", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic check_val(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
        checks++;
        assert (act_v === exp_v) else begin
            $display("ERR %0t %s expected 0x%08h actual 0x%08h", $time, name, exp_v, act_v);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        test_num++;
        if (errors == err_mark) begin
            $display("test %0d %s: pass", test_num, name);
        end else begin
            $display("test %0d %s: fail, %0d errors", test_num, name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    // row i of J lands in group i/4 at slot i%4
    task automatic fill_weights();
        logic [3:0] nib;
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                j_val[i][j] = ($random(seed) & 15) - 8;
                nib = 4'(j_val[i][j]);
                j_mem[i / 4][(i % 4) * N * 4 + j * 4 +: 4] = nib;
            end
            h_val[i] = ($random(seed) & 15) - 8;
            nib = 4'(h_val[i]);
            hbias_i[i * 4 +: 4] = nib;
        end
        hscaling_i = 4'($random(seed));
    endtask

    task automatic model_energy(input logic [N-1:0] s, output int e);
        int sum;
        int si;
        int sj;
        sum = 0;
        for (int i = 0; i < N; i++) begin
            si = s[i] ? 1 : -1;
            for (int j = 0; j < N; j++) begin
                sj = s[j] ? 1 : -1;
                sum += j_val[i][j] * si * sj;
            end
            sum += int'(hscaling_i) * h_val[i] * si;
        end
        e = -sum;
    endtask

    // first evaluation always kept and later ones greedy or unconditional
    task automatic model_run(input int count, input bit cmp, input logic [N-1:0] start,
                             output logic [N-1:0] exp_spin, output int exp_e);
        logic [N-1:0] cand;
        int           e;
        exp_spin = start;
        model_energy(start, exp_e);
        for (int k = 0; k < count; k++) begin
            cand = exp_spin ^ icon_mem[k];
            model_energy(cand, e);
            if (!cmp || e < exp_e) begin
                exp_spin = cand;
                exp_e    = e;
            end
        end
    endtask

    task automatic run_and_check(input int count, input bit cmp, input logic [N-1:0] start,
                                 input bit gaps);
        logic [N-1:0] exp_spin;
        int           exp_e;
        int           n;
        config_valid_i  = 1'b1;
        config_spin_i   = start;
        en_comparison_i = cmp;
        icon_count_i    = 5'(count);
        @(negedge clk_i);
        config_valid_i = 1'b0;
        cmpt_en_i      = 1'b1;
        @(negedge clk_i);
        cmpt_en_i = 1'b0;
        n = 0;
        while (!cmpt_idle_o && n < RUN_LIMIT) begin
            weight_valid_i = gaps ? (($random(seed) & 3) != 0) : 1'b1;
            @(negedge clk_i);
            n++;
        end
        weight_valid_i = 1'b1;
        assert (cmpt_idle_o) else begin
            $display("run did not finish, cmpt_idle_o stayed low for %0d cycles", n);
            errors++;
        end
        model_run(count, cmp, start, exp_spin, exp_e);
        check_val("spin_o", 32'(exp_spin), 32'(spin_o));
        check_val("energy_o", exp_e, energy_o);
        got_spin   = spin_o;
        got_energy = energy_o;
    endtask

    initial begin
        seed            = 6559;
        errors          = 0;
        checks          = 0;
        test_num        = 0;
        err_mark        = 0;
        arst_n_i        = 1'b0;
        config_valid_i  = 1'b0;
        config_spin_i   = '0;
        cmpt_en_i       = 1'b0;
        en_comparison_i = 1'b1;
        icon_count_i    = '0;
        weight_valid_i  = 1'b1;
        hbias_i         = '0;
        hscaling_i      = '0;
        for (int g = 0; g < 4; g++) begin
            j_mem[g] = '0;
        end
        repeat (16) @(negedge clk_i);
        arst_n_i = 1'b1;
        @(negedge clk_i);

        check_val("cmpt_idle_o", 32'd1, 32'(cmpt_idle_o));
        check_val("flip_ren_o", 32'd0, 32'(flip_ren_o));
        check_val("weight_ready_o", 32'd0, 32'(weight_ready_o));
        check_val("spin_o", 32'd0, 32'(spin_o));
        check_val("energy_o", 32'd0, energy_o);
        end_test("reset state");

        fill_weights();
        for (int k = 0; k < ICONS; k++) begin
            icon_mem[k] = N'($random(seed));
        end
        start_spin = N'($random(seed));

        run_and_check(0, 1'b1, start_spin, 1'b0);
        end_test("zero icons");

        run_and_check(ICONS, 1'b1, start_spin, 1'b0);
        ref_spin   = got_spin;
        ref_energy = got_energy;
        end_test("greedy run");

        run_and_check(ICONS, 1'b0, start_spin, 1'b0);
        end_test("comparison off");

        // result must not depend on the beat timing
        run_and_check(ICONS, 1'b1, start_spin, 1'b1);
        check_val("spin_o", 32'(ref_spin), 32'(got_spin));
        check_val("energy_o", ref_energy, got_energy);
        end_test("weight gaps");

        for (int r = 0; r < 3; r++) begin
            fill_weights();
            start_spin = N'($random(seed));
            run_and_check(ICONS, 1'b1, start_spin, 1'b1);
        end
        end_test("back-to-back runs");

        $display("%0d tests, %0d checks, %0d errors", test_num, checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== files.f ====
hdl/lagd_pkg.sv
hdl/energy_if.sv
hdl/step_counter.sv
hdl/energy_monitor.sv
hdl/flip_manager.sv
hdl/digital_macro.sv
verif/tb_digital_macro.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_digital_macro
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'TEST OK'

clean:
	rm -rf $(BUILD_DIR)
